// ==== compile.f ====
hdl/capture_pkg.sv
hdl/capture_sequencer.sv
hdl/word_router.sv
hdl/frame_assembler.sv
hdl/capture_framer_top.sv
dv/capture_framer_chk.sv
dv/tb_capture_framer.sv

// ==== dv/capture_framer_chk.sv ====
// framed output checker with concurrent assertions on the valid, first and last flags
module capture_framer_chk (
  input logic                      clk_245_76MHz,
  input logic                      cpu_reset,
  input capture_pkg::frame_word_t  frame_word_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // count of failed assertions
  int fail_count = 0;

  //////////////////////////////////////////////////
  // flag rules
  //////////////////////////////////////////////////
  // header flag only on a delivered word
  a_first_valid: assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    frame_word_i.first |-> frame_word_i.valid)
  else begin
    $error("first flag without valid");
    fail_count = fail_count + 1;
  end

  a_last_valid: assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    frame_word_i.last |-> frame_word_i.valid)
  else begin
    $error("last flag without valid");
    fail_count = fail_count + 1;
  end

  // gate shuts right after the trailer
  a_last_gap: assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    frame_word_i.last |=> !frame_word_i.valid)
  else begin
    $error("valid word directly after trailer");
    fail_count = fail_count + 1;
  end

  // reset clears all output flags
  a_reset_clear: assert property (@(posedge clk_245_76MHz)
    cpu_reset |=> !(frame_word_i.valid || frame_word_i.first || frame_word_i.last))
  else begin
    $error("output flags set after reset");
    fail_count = fail_count + 1;
  end

endmodule

// ==== dv/tb_capture_framer.sv ====
// capture framer testbench with LCG samples, reference model, compare process and cycle timeout
module tb_capture_framer;

  timeunit 1ns;
  timeprecision 1ps;

  import capture_pkg::*;

  localparam int RESET_CYCLES = 3;
  localparam int IDLE_CYCLES  = 40;
  localparam int NUM_CAPS     = 5;
  localparam int MAX_LEN      = 100;
  localparam int GAP_CYCLES   = 13;
  // per capture the enable time, the start settling and up to two blocks of words
  localparam int CYCLE_LIMIT  = RESET_CYCLES + IDLE_CYCLES
    + NUM_CAPS * (MAX_LEN + WFRM_START_DELAY + 2 * BLOCK_WORDS + GAP_CYCLES);
  localparam logic [31:0] HDR_TAG = "FRST";
  localparam logic [31:0] TRL_TAG = "LAST";
  localparam int KIND_DATA    = 0;
  localparam int KIND_HEADER  = 1;
  localparam int KIND_TRAILER = 2;

  logic          clk_245_76MHz;
  logic          cpu_reset;
  adc_sample_t   adc_sample_i;
  iq_sample_t    dac_sample_i;
  capture_ctrl_t capture_ctrl_i;
  logic          capture_init_i;
  logic          capture_enable_i;
  frame_word_t   frame_word_o;

  // scoreboard state
  logic [31:0] model_cnt;
  logic [31:0] adc_hist [16];
  logic [31:0] dac_hist [16];
  logic [31:0] rise_cnt;
  logic [31:0] hdr_cycle;
  logic [31:0] hdr_seen_at;
  logic        in_frame    = 1'b0;
  logic        prev_enable = 1'b0;
  int          out_count   = 0;
  int          frame_len   = 0;
  int          frames_seen = 0;
  int          cycle_total = 0;
  int          latency_q [$];

  capture_framer_top i_dut (
    .clk_245_76MHz    (clk_245_76MHz),
    .cpu_reset        (cpu_reset),
    .adc_sample_i     (adc_sample_i),
    .dac_sample_i     (dac_sample_i),
    .capture_ctrl_i   (capture_ctrl_i),
    .capture_init_i   (capture_init_i),
    .capture_enable_i (capture_enable_i),
    .frame_word_o     (frame_word_o)
  );

  bind capture_framer_top capture_framer_chk i_capture_framer_chk (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .frame_word_i  (frame_word_o)
  );

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // payload of one half word for a given route
  function automatic logic [31:0] select_half(input route_sel_e sel, input logic [31:0] cyc,
                                              input logic [31:0] smp, input logic [31:0] adc,
                                              input logic [31:0] dac);
    logic [31:0] res;
    case (sel)
      ROUTE_ADC_IQ:     res = adc;
      ROUTE_DAC_IQ:     res = dac;
      ROUTE_SAMPLE_CNT: res = smp;
      default:          res = cyc;
    endcase
    return res;
  endfunction

  // expected framed word with the tag below the write-cycle timestamp or two routed halves
  function automatic logic [63:0] expected_word(input int kind, input route_sel_e upper,
                                                input route_sel_e lower, input logic [31:0] cyc,
                                                input logic [31:0] smp, input logic [31:0] adc,
                                                input logic [31:0] dac);
    logic [63:0] res;
    if (kind == KIND_HEADER) begin
      res = {cyc, HDR_TAG};
    end else if (kind == KIND_TRAILER) begin
      res = {cyc, TRL_TAG};
    end else begin
      res = {select_half(upper, cyc, smp, adc, dac), select_half(lower, cyc, smp, adc, dac)};
    end
    return res;
  endfunction

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("FAILED at %0d ns: %s, got %h expected %h", $time, what, actual, expected);
      $display("TEST FAIL");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // one capture of len enabled cycles with an optional source switch on the enable edge
  task automatic run_capture(input route_sel_e upper, input route_sel_e lower,
                             input source_e src_idle, input source_e src_at_rise,
                             input int len);
    int frames_before;
    frames_before = frames_seen;
    @(posedge clk_245_76MHz);
    capture_ctrl_i <= '{route_lower: lower, route_upper: upper, source: src_idle};
    repeat (4) @(posedge clk_245_76MHz);
    capture_enable_i      <= 1'b1;
    capture_init_i        <= 1'b1;
    capture_ctrl_i.source <= src_at_rise;
    @(posedge clk_245_76MHz);
    capture_init_i <= 1'b0;
    repeat (len - 1) @(posedge clk_245_76MHz);
    capture_enable_i <= 1'b0;
    // wait for the trailer of this frame
    wait (frames_seen != frames_before);
    repeat (8) @(posedge clk_245_76MHz);
  endtask

  //////////////////////////////////////////////////
  // clock, stimulus, free running model counter
  //////////////////////////////////////////////////
  initial begin
    clk_245_76MHz = 1'b0;
    forever #50 clk_245_76MHz = ~clk_245_76MHz;
  end

  // adc and dac pairs from the lcg with adc always valid
  initial begin : sample_drive
    logic [31:0] lcg_state;
    lcg_state    = 32'd2;
    adc_sample_i = '0;
    dac_sample_i = '0;
    forever begin
      @(posedge clk_245_76MHz);
      lcg_state = lcg_next(lcg_state);
      adc_sample_i <= {lcg_state, 1'b1};
      lcg_state = lcg_next(lcg_state);
      dac_sample_i <= lcg_state;
    end
  end

  always @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      model_cnt <= '0;
    end else begin
      model_cnt <= model_cnt + 1'b1;
    end
  end

  always @(posedge clk_245_76MHz) begin
    cycle_total <= cycle_total + 1;
    if (cycle_total >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TEST FAIL");
      $fatal(1, "cycle limit reached");
    end
  end

  //////////////////////////////////////////////////
  // compare process sampled mid cycle
  //////////////////////////////////////////////////
  always @(negedge clk_245_76MHz) begin : compare_proc
    logic [31:0] wr_cnt;
    logic [31:0] cyc;
    logic [63:0] exp_word;
    if (!cpu_reset) begin
      check_value(i_dut.i_capture_framer_chk.fail_count, 0, "concurrent assertion failed");
      // output is one cycle behind its write cycle
      wr_cnt = model_cnt - 1'b1;
      cyc    = hdr_cycle + (model_cnt - hdr_seen_at);
      if (capture_enable_i && !prev_enable) begin
        rise_cnt = model_cnt;
      end
      prev_enable = capture_enable_i;
      if (frame_word_o.valid && frame_word_o.first) begin
        check_value(in_frame, 1'b0, "header inside an open frame");
        exp_word = expected_word(KIND_HEADER, capture_ctrl_i.route_upper,
                                 capture_ctrl_i.route_lower, wr_cnt, out_count,
                                 adc_hist[wr_cnt[3:0]], dac_hist[wr_cnt[3:0]]);
        check_value(frame_word_o.data, exp_word, "header word");
        in_frame    = 1'b1;
        frame_len   = 1;
        hdr_cycle   = wr_cnt;
        hdr_seen_at = model_cnt;
        latency_q.push_back(int'(wr_cnt - rise_cnt));
      end else if (frame_word_o.valid) begin
        check_value(in_frame, 1'b1, "valid word outside a frame");
        frame_len++;
        exp_word = expected_word(frame_word_o.last ? KIND_TRAILER : KIND_DATA,
                                 capture_ctrl_i.route_upper, capture_ctrl_i.route_lower,
                                 cyc, out_count, adc_hist[wr_cnt[3:0]], dac_hist[wr_cnt[3:0]]);
        check_value(frame_word_o.data, exp_word,
                    frame_word_o.last ? "trailer word" : "data word");
        if (frame_word_o.last) begin
          check_value(frame_len % BLOCK_WORDS, 0, "frame length not padded to a block");
          in_frame = 1'b0;
          frames_seen++;
        end
      end else if (in_frame) begin
        check_value(1'b0, 1'b1, "valid dropped inside a frame");
      end
      if (frame_word_o.valid) begin
        out_count++;
      end
      adc_hist[model_cnt[3:0]] = adc_sample_i.iq;
      dac_hist[model_cnt[3:0]] = dac_sample_i;
    end
  end

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////
  initial begin
    cpu_reset        = 1'b1;
    capture_init_i   = 1'b0;
    capture_enable_i = 1'b0;
    capture_ctrl_i   = '{route_lower: ROUTE_ADC_IQ, route_upper: ROUTE_ADC_IQ, source: SRC_CHIRP};
    repeat (RESET_CYCLES) @(posedge clk_245_76MHz);
    cpu_reset <= 1'b0;
    repeat (IDLE_CYCLES) @(posedge clk_245_76MHz);
    check_value(out_count, 0, "valid word while capture enable low");
    run_capture(ROUTE_ADC_IQ, ROUTE_ADC_IQ, SRC_CHIRP, SRC_CHIRP, 30);
    run_capture(ROUTE_CYCLE_CNT, ROUTE_SAMPLE_CNT, SRC_CHIRP, SRC_CHIRP, 70);
    run_capture(ROUTE_DAC_IQ, ROUTE_ADC_IQ, SRC_WAVEFORM, SRC_WAVEFORM, MAX_LEN);
    // source switched on the enable edge stays chirp for this frame
    run_capture(ROUTE_ADC_IQ, ROUTE_DAC_IQ, SRC_CHIRP, SRC_WAVEFORM, 45);
    run_capture(ROUTE_SAMPLE_CNT, ROUTE_CYCLE_CNT, SRC_WAVEFORM, SRC_WAVEFORM, 40);
    check_value(frames_seen, NUM_CAPS, "number of trailers");
    check_value(latency_q[3], latency_q[0], "header latency after source change");
    check_value(latency_q[4], latency_q[2], "waveform header latency");
    check_value(latency_q[2] > latency_q[0], 1'b1, "waveform header not later than chirp");
    check_value(i_dut.i_capture_framer_chk.fail_count, 0, "assertion failures");
    $display("TEST PASS");
    $finish;
  end

endmodule

// ==== hdl/capture_framer_top.sv ====
// capture framer top: sequencer and router side by side feeding the frame assembler
module capture_framer_top (
  input  logic                        clk_245_76MHz,
  input  logic                        cpu_reset,
  input  capture_pkg::adc_sample_t    adc_sample_i,
  input  capture_pkg::iq_sample_t     dac_sample_i,
  input  capture_pkg::capture_ctrl_t  capture_ctrl_i,
  input  logic                        capture_init_i,
  input  logic                        capture_enable_i,
  output capture_pkg::frame_word_t    frame_word_o
);

  import capture_pkg::*;

  // sequencer outputs
  logic              gate;
  logic              count_en;
  logic              frame_start;
  logic              frame_end;

  // router outputs
  source_e           source;
  logic [WORD_W-1:0] routed_word;
  logic [CNT_W-1:0]  cycle_count;

  //////////////////////////////////////////////////
  // gate and strobes
  //////////////////////////////////////////////////
  capture_sequencer i_capture_sequencer (
    .clk_245_76MHz    (clk_245_76MHz),
    .cpu_reset        (cpu_reset),
    .capture_init_i   (capture_init_i),
    .capture_enable_i (capture_enable_i),
    .adc_valid_i      (adc_sample_i.valid),
    .source_i         (source),
    .gate_o           (gate),
    .count_en_o       (count_en),
    .frame_start_o    (frame_start),
    .frame_end_o      (frame_end)
  );

  // payload selection and counters
  word_router i_word_router (
    .clk_245_76MHz    (clk_245_76MHz),
    .cpu_reset        (cpu_reset),
    .capture_ctrl_i   (capture_ctrl_i),
    .capture_enable_i (capture_enable_i),
    .adc_iq_i         (adc_sample_i.iq),
    .dac_iq_i         (dac_sample_i),
    .count_en_i       (count_en),
    .source_o         (source),
    .routed_word_o    (routed_word),
    .cycle_count_o    (cycle_count)
  );

  //////////////////////////////////////////////////
  // output framing
  //////////////////////////////////////////////////
  frame_assembler i_frame_assembler (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .gate_i        (gate),
    .adc_valid_i   (adc_sample_i.valid),
    .frame_start_i (frame_start),
    .frame_end_i   (frame_end),
    .routed_word_i (routed_word),
    .cycle_count_i (cycle_count),
    .frame_word_o  (frame_word_o)
  );

endmodule

// ==== hdl/capture_pkg.sv ====
// capture framing package: frame constants, settling delays, enums and bundled types
package capture_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////
  localparam int IQ_W        = 16;
  localparam int IQ_PAIR_W   = 2 * IQ_W;
  localparam int WORD_W      = 64;
  localparam int CNT_W       = 32;
  localparam int DELAY_W     = 8;

  // frame length incl. header and trailer is padded to this
  localparam int BLOCK_WORDS = 64;
  // word counter / alignment counter width
  localparam int ALIGN_W     = $clog2(BLOCK_WORDS);

  // ascii FRST / LAST tags for the lower half of header and trailer
  localparam logic [IQ_PAIR_W-1:0] FIRST_TAG = 32'h4652_5354;
  localparam logic [IQ_PAIR_W-1:0] LAST_TAG  = 32'h4c41_5354;

  //////////////////////////////////////////////////
  // settling delays per source
  //////////////////////////////////////////////////
  // chirp dds settles the same at start and end
  localparam logic [DELAY_W-1:0] CHIRP_DELAY      = 8'd4;
  localparam logic [DELAY_W-1:0] WFRM_START_DELAY = 8'd19;
  localparam logic [DELAY_W-1:0] WFRM_END_DELAY   = 8'd2;

  // what goes into one 32-bit half of a word
  typedef enum logic [1:0] {
    ROUTE_ADC_IQ     = 2'b00,
    ROUTE_DAC_IQ     = 2'b01,
    ROUTE_SAMPLE_CNT = 2'b10,
    ROUTE_CYCLE_CNT  = 2'b11
  } route_sel_e;

  typedef enum logic {
    SRC_CHIRP    = 1'b0,
    SRC_WAVEFORM = 1'b1
  } source_e;

  // i sits in the upper half
  typedef struct packed {
    logic [IQ_W-1:0] i;
    logic [IQ_W-1:0] q;
  } iq_sample_t;

  typedef struct packed {
    iq_sample_t iq;
    logic       valid;
  } adc_sample_t;

  typedef struct packed {
    route_sel_e route_lower;
    route_sel_e route_upper;
    source_e    source;
  } capture_ctrl_t;

  typedef struct packed {
    logic [WORD_W-1:0] data;
    logic              valid;
    logic              first;
    logic              last;
  } frame_word_t;

endpackage

// ==== hdl/capture_sequencer.sv ====
// capture sequencer: settling delay, capture gate, block alignment and frame strobes
module capture_sequencer (
  input  logic                clk_245_76MHz,
  input  logic                cpu_reset,
  input  logic                capture_init_i,
  input  logic                capture_enable_i,
  input  logic                adc_valid_i,
  input  capture_pkg::source_e source_i,
  output logic                gate_o,
  output logic                count_en_o,
  output logic                frame_start_o,
  output logic                frame_end_o
);

  import capture_pkg::*;

  logic               enable_d;
  logic [DELAY_W-1:0] delay_cnt;
  logic               gate_q;
  logic               start_q;
  logic [ALIGN_W-1:0] word_cnt;
  logic [ALIGN_W-1:0] align_cnt;

  logic delay_zero;
  logic delay_one;
  logic aligning;
  logic enable_fall;
  logic start_cond;
  logic pre_end;
  logic write_en;

  //////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////
  assign delay_zero  = (delay_cnt == '0);
  assign delay_one   = (delay_cnt == DELAY_W'(1));
  assign aligning    = |align_cnt;
  // enable_d drops on the next edge
  assign enable_fall = enable_d & ~capture_enable_i;
  // settled, enabled, gate still shut
  assign start_cond  = delay_zero & enable_d & ~gate_q;
  // one cycle before the end delay runs out
  assign pre_end     = delay_one & gate_q & ~enable_d;
  assign write_en    = gate_q & adc_valid_i;

  // enable pipeline
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      enable_d <= 1'b0;
    end else begin
      enable_d <= capture_enable_i;
    end
  end

  //////////////////////////////////////////////////
  // settling delay counter
  //////////////////////////////////////////////////
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      delay_cnt <= '0;
    end else if (capture_init_i) begin
      // start delay, waveform source is much slower
      delay_cnt <= (source_i == SRC_WAVEFORM) ? WFRM_START_DELAY : CHIRP_DELAY;
    end else if (enable_fall) begin
      delay_cnt <= (source_i == SRC_WAVEFORM) ? WFRM_END_DELAY : CHIRP_DELAY;
    end else if (!delay_zero) begin
      delay_cnt <= delay_cnt - 1'b1;
    end
  end

  // gate follows enable_d once settled, frozen while padding
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      gate_q <= 1'b0;
    end else if (delay_zero && !aligning) begin
      gate_q <= enable_d;
    end
  end

  // header flag, lines up with the first gated cycle
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      start_q <= 1'b0;
    end else begin
      start_q <= start_cond;
    end
  end

  //////////////////////////////////////////////////
  // block alignment
  //////////////////////////////////////////////////
  // words written in this frame, modulo block size
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      word_cnt <= '0;
    end else if (start_cond) begin
      word_cnt <= '0;
    end else if (write_en) begin
      word_cnt <= word_cnt + 1'b1;
    end
  end

  // pad writes still owed before the trailer
  // ones complement of the count incl. this cycle leaves room for the trailer
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      align_cnt <= '0;
    end else if (pre_end) begin
      align_cnt <= ~(word_cnt + {{(ALIGN_W-1){1'b0}}, adc_valid_i});
    end else if (aligning && write_en) begin
      align_cnt <= align_cnt - 1'b1;
    end
  end

  assign gate_o        = gate_q;
  assign count_en_o    = write_en;
  assign frame_start_o = start_q;
  // trailer cycle, gate shuts on the next edge
  assign frame_end_o   = delay_zero & gate_q & ~enable_d & ~aligning;

endmodule

// ==== hdl/frame_assembler.sv ====
// frame assembler: header and trailer insertion, registered framed output word
module frame_assembler (
  input  logic                               clk_245_76MHz,
  input  logic                               cpu_reset,
  input  logic                               gate_i,
  input  logic                               adc_valid_i,
  input  logic                               frame_start_i,
  input  logic                               frame_end_i,
  input  logic [capture_pkg::WORD_W-1:0]     routed_word_i,
  input  logic [capture_pkg::CNT_W-1:0]      cycle_count_i,
  output capture_pkg::frame_word_t           frame_word_o
);

  import capture_pkg::*;

  logic                 write_en;
  logic                 is_last;
  logic [IQ_PAIR_W-1:0] tag;
  logic [WORD_W-1:0]    word_mux;

  logic [WORD_W-1:0]    data_q;
  logic                 valid_q;
  logic                 first_q;
  logic                 last_q;

  assign write_en = gate_i & adc_valid_i;
  // header wins over trailer
  assign is_last  = frame_end_i & ~frame_start_i;
  assign tag      = is_last ? LAST_TAG : FIRST_TAG;

  // timestamp on top, tag below
  assign word_mux = (frame_start_i || frame_end_i) ? {cycle_count_i, tag} : routed_word_i;

  //////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      valid_q <= 1'b0;
      first_q <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      valid_q <= write_en;
      first_q <= write_en & frame_start_i;
      last_q  <= write_en & is_last;
    end
  end

  // payload
  always_ff @(posedge clk_245_76MHz) begin
    if (write_en) begin
      data_q <= word_mux;
    end
  end

  assign frame_word_o = '{data: data_q, valid: valid_q, first: first_q, last: last_q};

endmodule

// ==== hdl/word_router.sv ====
// word router with control register, sample and cycle counters and half-word route selection
module word_router (
  input  logic                               clk_245_76MHz,
  input  logic                               cpu_reset,
  input  capture_pkg::capture_ctrl_t         capture_ctrl_i,
  input  logic                               capture_enable_i,
  input  capture_pkg::iq_sample_t            adc_iq_i,
  input  capture_pkg::iq_sample_t            dac_iq_i,
  input  logic                               count_en_i,
  output capture_pkg::source_e               source_o,
  output logic [capture_pkg::WORD_W-1:0]     routed_word_o,
  output logic [capture_pkg::CNT_W-1:0]      cycle_count_o
);

  import capture_pkg::*;

  route_sel_e             route_lower_q;
  route_sel_e             route_upper_q;
  source_e                source_q;
  logic [CNT_W-1:0]       cycle_cnt;
  logic [CNT_W-1:0]       sample_cnt;
  logic [IQ_PAIR_W-1:0]   half_upper;
  logic [IQ_PAIR_W-1:0]   half_lower;

  // pick one 32-bit payload for a half word
  function automatic logic [IQ_PAIR_W-1:0] route_half(input route_sel_e sel);
    logic [IQ_PAIR_W-1:0] res;
    case (sel)
      ROUTE_ADC_IQ:     res = adc_iq_i;
      ROUTE_DAC_IQ:     res = dac_iq_i;
      ROUTE_SAMPLE_CNT: res = sample_cnt;
      default:          res = cycle_cnt;
    endcase
    return res;
  endfunction

  //////////////////////////////////////////////////
  // control word
  //////////////////////////////////////////////////
  // routes take effect one cycle after the input
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      route_lower_q <= ROUTE_ADC_IQ;
      route_upper_q <= ROUTE_ADC_IQ;
    end else begin
      route_lower_q <= capture_ctrl_i.route_lower;
      route_upper_q <= capture_ctrl_i.route_upper;
    end
  end

  // source locked for the whole capture
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      source_q <= SRC_CHIRP;
    end else if (!capture_enable_i) begin
      source_q <= capture_ctrl_i.source;
    end
  end

  //////////////////////////////////////////////////
  // counters
  //////////////////////////////////////////////////
  // free running timestamp
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      cycle_cnt <= '0;
    end else begin
      cycle_cnt <= cycle_cnt + 1'b1;
    end
  end

  // written words since reset
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      sample_cnt <= '0;
    end else if (count_en_i) begin
      sample_cnt <= sample_cnt + 1'b1;
    end
  end

  always_comb begin
    half_upper = route_half(route_upper_q);
    half_lower = route_half(route_lower_q);
  end

  assign source_o      = source_q;
  assign routed_word_o = {half_upper, half_lower};
  assign cycle_count_o = cycle_cnt;

endmodule
